//--- Makefile
# Verilator build for the rv32i core testbench.

TOP := tb_rv_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- core_vectors.hex
// words 0x00-0x3f: program, one instruction per word from address 0
// @40: store count, then expected store address and data pairs
@00
00700093 FFD00113 002081B3 40208233 0020F2B3 0020E333 0020C3B3 00112433
001134B3 12345537 10302023 10402223 10502423 10602623 10702823 10802A23
10902C23 10A02E23 00108593 00B58633 12C02023 10402683 00168733 12E02223
00108663 1E102823 1E102A23 00209663 1E202C23 1E202E23 00C007EF 1E102823
1E102823 12F02423 00500013 12002623 0000006F
@40
0000000C
00000100 00000004
00000104 0000000A
00000108 00000005
0000010C FFFFFFFF
00000110 FFFFFFFA
00000114 00000001
00000118 00000000
0000011C 12345000
00000120 00000010
00000124 00000011
00000128 0000007C
0000012C 00000000

//--- decode.sv
`timescale 1ns/1ps
/* decode
   field extraction, immediates and operand selection toward execute.
   raises hazard and sends a bubble when a source is still being produced. */
module decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall_i,
    input  logic [rv_pkg::XLEN-1:0]       instruction_i,
    input  logic [rv_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_pkg::TAG_W-1:0]      tag_i,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [rv_pkg::XLEN-1:0]       first_operand_o,
    output logic [rv_pkg::XLEN-1:0]       second_operand_o,
    output logic [rv_pkg::XLEN-1:0]       third_operand_o,
    output logic [rv_pkg::XLEN-1:0]       pc_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
    output rv_pkg::op_e                   op_o,
    output logic                          write_enable_o,
    output logic [rv_pkg::TAG_W-1:0]      tag_o,
    output logic                          hazard_o
);
    logic                    replay;
    logic [rv_pkg::XLEN-1:0] held_word, word;
    rv_pkg::instr_u          instr;
    rv_pkg::op_e             op;
    logic                    use_rs1, use_rs2, writes_rd;
    logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, second, third;

    // a word not consumed last cycle is decoded again, the memory has moved on.
    assign word  = replay ? held_word : instruction_i;
    assign instr = word;
    assign rs1_o = instr.r.rs1;
    assign rs2_o = instr.r.rs2;

    // the first word after reset was addressed during reset, a zero word stands in.
    always_ff @(posedge clk) begin
        if (reset) begin
            replay    <= 1'b1;
            held_word <= '0;
        end else begin
            replay    <= stall_i || hazard_o;
            held_word <= word;
        end
    end

    always_comb begin
        op = rv_pkg::NOP;  // anything not decoded retires as a nop.
        case (instr.r.opcode)
            rv_pkg::OPC_OP: begin
                if (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000) begin
                    op = rv_pkg::SUB;
                end else if (instr.r.funct7 == 7'b0) begin
                    case (instr.r.funct3)
                        3'b000:  op = rv_pkg::ADD;
                        3'b010:  op = rv_pkg::SLT;
                        3'b011:  op = rv_pkg::SLTU;
                        3'b100:  op = rv_pkg::XOR;
                        3'b110:  op = rv_pkg::OR;
                        3'b111:  op = rv_pkg::AND;
                        default: op = rv_pkg::NOP;
                    endcase
                end
            end
            rv_pkg::OPC_OP_IMM: if (instr.i.funct3 == 3'b000) op = rv_pkg::ADD;  // addi.
            rv_pkg::OPC_LUI:    op = rv_pkg::LUI;
            rv_pkg::OPC_LOAD:   if (instr.i.funct3 == 3'b010) op = rv_pkg::LW;
            rv_pkg::OPC_STORE:  if (instr.s.funct3 == 3'b010) op = rv_pkg::SW;
            rv_pkg::OPC_BRANCH: begin
                if (instr.s.funct3 == 3'b000) op = rv_pkg::BEQ;
                if (instr.s.funct3 == 3'b001) op = rv_pkg::BNE;
            end
            rv_pkg::OPC_JAL:    op = rv_pkg::JAL;
            default:            op = rv_pkg::NOP;
        endcase
    end

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                    instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        second  = rs2_data_i;
        third   = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (instr.r.opcode)
            rv_pkg::OPC_OP:                      use_rs2 = 1'b1;
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD: second = imm_i;
            rv_pkg::OPC_STORE: begin
                second  = imm_s;
                third   = rs2_data_i;  // store data.
                use_rs2 = 1'b1;
            end
            rv_pkg::OPC_BRANCH:                  use_rs2 = 1'b1;
            rv_pkg::OPC_LUI: begin
                second  = imm_u;
                use_rs1 = 1'b0;
            end
            rv_pkg::OPC_JAL: begin
                third   = imm_j;
                use_rs1 = 1'b0;
            end
            default:                             use_rs1 = 1'b0;
        endcase
    end

    assign writes_rd = !(op inside {rv_pkg::NOP, rv_pkg::SW, rv_pkg::BEQ, rv_pkg::BNE});

    // the result of the instruction in execute reaches the bypass only at retire.
    assign hazard_o = write_enable_o && rd_o != '0 &&
                      ((use_rs1 && instr.r.rs1 == rd_o) || (use_rs2 && instr.r.rs2 == rd_o));

    always_ff @(posedge clk) begin
        if (reset) begin
            op_o           <= rv_pkg::NOP;
            write_enable_o <= 1'b0;
            tag_o          <= '0;
        end else if (!stall_i) begin
            op_o           <= hazard_o ? rv_pkg::NOP : op;  // bubble.
            write_enable_o <= writes_rd && !hazard_o;
            tag_o          <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            first_operand_o  <= rs1_data_i;
            second_operand_o <= second;
            third_operand_o  <= third;
            pc_o             <= pc_i;
            rd_o             <= instr.r.rd;
        end
    end

endmodule

//--- execute.sv
`timescale 1ns/1ps
/* execute
   alu, branch decision and memory request, then the pipeline register toward retire. */
module execute (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall_i,
    input  logic [rv_pkg::XLEN-1:0]       first_operand_i,
    input  logic [rv_pkg::XLEN-1:0]       second_operand_i,
    input  logic [rv_pkg::XLEN-1:0]       third_operand_i,
    input  logic [rv_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  rv_pkg::op_e                   op_i,
    input  logic                          write_enable_i,
    input  logic [rv_pkg::TAG_W-1:0]      tag_i,
    output logic [rv_pkg::XLEN-1:0]       result_o,
    output logic [rv_pkg::XLEN-1:0]       jump_target_o,
    output logic                          jump_o,
    output logic                          write_enable_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
    output rv_pkg::op_e                   op_o,
    output logic [rv_pkg::TAG_W-1:0]      tag_o,
    output logic [rv_pkg::XLEN-1:0]       mem_address_o,
    output logic [rv_pkg::XLEN-1:0]       mem_write_data_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o
);
    logic [rv_pkg::XLEN-1:0] a, b, alu;
    logic                    less, less_u, taken;

    assign a      = first_operand_i;
    assign b      = second_operand_i;
    assign less   = $signed(a) < $signed(b);
    assign less_u = a < b;

    always_comb begin
        case (op_i)
            rv_pkg::SUB:  alu = a - b;
            rv_pkg::AND:  alu = a & b;
            rv_pkg::OR:   alu = a | b;
            rv_pkg::XOR:  alu = a ^ b;
            rv_pkg::SLT:  alu = {{(rv_pkg::XLEN-1){1'b0}}, less};
            rv_pkg::SLTU: alu = {{(rv_pkg::XLEN-1){1'b0}}, less_u};
            rv_pkg::LUI:  alu = b;
            rv_pkg::JAL:  alu = pc_i + 32'd4;  // link address.
            default:      alu = a + b;
        endcase
    end

    assign taken = (op_i == rv_pkg::JAL) ||
                   (op_i == rv_pkg::BEQ && a == b) ||
                   (op_i == rv_pkg::BNE && a != b);

    // memory request straight from the operands, gated at the top.
    assign mem_address_o    = a + b;
    assign mem_write_data_o = third_operand_i;
    assign mem_read_o       = op_i == rv_pkg::LW;
    assign mem_write_o      = op_i == rv_pkg::SW;

    always_ff @(posedge clk) begin
        if (reset) begin
            jump_o         <= 1'b0;
            write_enable_o <= 1'b0;
            op_o           <= rv_pkg::NOP;
            tag_o          <= '0;
        end else if (!stall_i) begin
            jump_o         <= taken;
            write_enable_o <= write_enable_i;
            op_o           <= op_i;
            tag_o          <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o      <= alu;
            jump_target_o <= pc_i + third_operand_i;  // branch or jal offset.
            rd_o          <= rd_i;
        end
    end

endmodule

//--- fetch.sv
`timescale 1ns/1ps
/* fetch
   program counter with jump redirect, kill tag generation and hold on stall or hazard. */
module fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall_i,
    input  logic                     hazard_i,
    input  logic                     jump_i,
    input  logic [rv_pkg::XLEN-1:0]  jump_target_i,
    output logic [rv_pkg::XLEN-1:0]  instruction_address_o,
    output logic [rv_pkg::XLEN-1:0]  pc_o,
    output logic [rv_pkg::TAG_W-1:0] tag_o
);
    logic [rv_pkg::XLEN-1:0]  pc;
    logic [rv_pkg::TAG_W-1:0] tag;
    logic                     hold;

    assign hold                  = stall_i || hazard_i;
    assign instruction_address_o = pc;

    // a jump is issued only once, so it wins over stall and hazard.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= rv_pkg::RESET_PC;
            tag <= '0;
        end else if (jump_i) begin
            pc  <= jump_target_i;
            tag <= tag + 1'b1;  // older instructions now carry a stale tag.
        end else if (!hold) begin
            pc <= pc + 32'd4;
        end
    end

    // pc and tag of the word the memory returns next cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o  <= rv_pkg::RESET_PC;
            tag_o <= '0;
        end else if (!hold) begin
            pc_o  <= pc;
            tag_o <= tag;
        end
    end

endmodule

//--- regbank.sv
`timescale 1ns/1ps
/* regbank
   31 writable registers with two combinational read ports, x0 reads zero. */
module regbank (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          write_enable_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_pkg::XLEN-1:0]       data_i,
    output logic [rv_pkg::XLEN-1:0]       data1_o,
    output logic [rv_pkg::XLEN-1:0]       data2_o
);
    logic [rv_pkg::XLEN-1:0] regs [1:31];  // no storage behind x0.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable_i && rd_i != '0) begin
            regs[rd_i] <= data_i;  // writes to x0 fall away here.
        end
    end

    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- retire.sv
`timescale 1ns/1ps
/* retire
   kills wrong-path instructions by tag, selects write-back data and issues jumps. */
module retire (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::XLEN-1:0]       result_i,
    input  logic [rv_pkg::XLEN-1:0]       jump_target_i,
    input  logic                          jump_i,
    input  logic                          write_enable_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
    input  rv_pkg::op_e                   op_i,
    input  logic [rv_pkg::TAG_W-1:0]      tag_i,
    input  logic [rv_pkg::XLEN-1:0]       mem_data_i,
    output logic                          regbank_write_enable_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] regbank_rd_o,
    output logic [rv_pkg::XLEN-1:0]       regbank_data_o,
    output logic [rv_pkg::XLEN-1:0]       jump_target_o,
    output logic                          jump_o,
    output logic [rv_pkg::TAG_W-1:0]      current_tag_o
);
    logic [rv_pkg::TAG_W-1:0] current_tag;
    logic                     killed;

    assign killed = tag_i != current_tag;  // fetched before the last jump.

    assign regbank_write_enable_o = write_enable_i && !killed;
    assign regbank_rd_o           = rd_i;
    assign regbank_data_o         = (op_i == rv_pkg::LW) ? mem_data_i : result_i;

    // a held jump sees the new tag after the first edge and kills itself.
    assign jump_o        = jump_i && !killed;
    assign jump_target_o = jump_target_i;
    assign current_tag_o = current_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag <= '0;
        end else if (jump_o) begin
            current_tag <= current_tag + 1'b1;  // steps together with fetch.
        end
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
/* rv_core
   four stage rv32i core top. holds the write-back bypass and the memory enable gating. */
module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  logic [rv_pkg::XLEN-1:0] instruction_i,
    input  logic [rv_pkg::XLEN-1:0] mem_data_i,
    output logic [rv_pkg::XLEN-1:0] instruction_address_o,
    output logic [rv_pkg::XLEN-1:0] mem_address_o,
    output logic [rv_pkg::XLEN-1:0] mem_data_o,
    output logic                    mem_operation_enable_o,
    output logic                    mem_write_enable_o
);
    logic [rv_pkg::XLEN-1:0]       pc_decode, pc_execute;
    logic [rv_pkg::TAG_W-1:0]      tag_decode, tag_execute, tag_retire, current_tag;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1, rs2, rd_execute, rd_retire, wb_rd;
    logic [rv_pkg::XLEN-1:0]       bank_data1, bank_data2, rs1_data, rs2_data, wb_data;
    logic [rv_pkg::XLEN-1:0]       first_operand, second_operand, third_operand;
    logic [rv_pkg::XLEN-1:0]       result_retire, target_retire, jump_target;
    rv_pkg::op_e                   op_execute, op_retire;
    logic                          hazard, we_execute, we_retire, jump_retire;
    logic                          wb_we, jump, mem_read, mem_write, kill_execute;

    // a value written this cycle is not yet visible in the bank.
    assign rs1_data = (wb_we && wb_rd != '0 && rs1 == wb_rd) ? wb_data : bank_data1;
    assign rs2_data = (wb_we && wb_rd != '0 && rs2 == wb_rd) ? wb_data : bank_data2;

    assign kill_execute           = (tag_execute != current_tag) || jump;
    assign mem_operation_enable_o = (mem_read || mem_write) && !kill_execute && !stall_i;
    assign mem_write_enable_o     = mem_write;

    fetch i_fetch (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard),
        .jump_i(jump), .jump_target_i(jump_target),
        .instruction_address_o(instruction_address_o),
        .pc_o(pc_decode), .tag_o(tag_decode)
    );

    decode i_decode (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .instruction_i(instruction_i), .pc_i(pc_decode), .tag_i(tag_decode),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_o(rs1), .rs2_o(rs2),
        .first_operand_o(first_operand),
        .second_operand_o(second_operand),
        .third_operand_o(third_operand),
        .pc_o(pc_execute), .rd_o(rd_execute), .op_o(op_execute),
        .write_enable_o(we_execute), .tag_o(tag_execute), .hazard_o(hazard)
    );

    regbank i_regbank (
        .clk(clk), .reset(reset), .write_enable_i(wb_we),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(wb_rd), .data_i(wb_data),
        .data1_o(bank_data1), .data2_o(bank_data2)
    );

    execute i_execute (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .first_operand_i(first_operand),
        .second_operand_i(second_operand),
        .third_operand_i(third_operand),
        .pc_i(pc_execute), .rd_i(rd_execute), .op_i(op_execute),
        .write_enable_i(we_execute), .tag_i(tag_execute),
        .result_o(result_retire), .jump_target_o(target_retire),
        .jump_o(jump_retire), .write_enable_o(we_retire),
        .rd_o(rd_retire), .op_o(op_retire), .tag_o(tag_retire),
        .mem_address_o(mem_address_o), .mem_write_data_o(mem_data_o),
        .mem_read_o(mem_read), .mem_write_o(mem_write)
    );

    retire i_retire (
        .clk(clk), .reset(reset),
        .result_i(result_retire), .jump_target_i(target_retire),
        .jump_i(jump_retire), .write_enable_i(we_retire),
        .rd_i(rd_retire), .op_i(op_retire), .tag_i(tag_retire),
        .mem_data_i(mem_data_i),
        .regbank_write_enable_o(wb_we), .regbank_rd_o(wb_rd),
        .regbank_data_o(wb_data), .jump_target_o(jump_target),
        .jump_o(jump), .current_tag_o(current_tag)
    );

endmodule

//--- rv_pkg.sv
/* rv_pkg
   widths, major opcodes, operation set and instruction word views of the rv32i core. */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLT, SLTU, LUI,
        LW, SW,
        BEQ, BNE, JAL
    } op_e;

    // one word, three field layouts.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;  // also carries the branch offset high bits.
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } instr_u;

endpackage

//--- tb_checker.sv
`timescale 1ns/1ps
/* tb_checker
   compares every enabled store at the core ports with the expected list, in order,
   and checks the fetch address in the first cycle after reset. */
module tb_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    input  logic [31:0] instruction_address_i,
    input  logic        mem_operation_enable_i,
    input  logic        mem_write_enable_i,
    input  logic [31:0] mem_address_i,
    input  logic [31:0] mem_data_i,
    input  logic [31:0] expected_address_i [0:15],
    input  logic [31:0] expected_data_i [0:15],
    input  int          expected_count_i,
    output int          store_count_o,
    output int          checked_count_o,
    output int          error_count_o
);
    logic was_reset;

    function automatic string test_name(input int index);
        if (index < 8) return "alu_and_immediates";
        else if (index == 8) return "back_to_back_dependency";
        else if (index == 9) return "load_after_store";
        else if (index == 10) return "jal_link";
        else return "x0_write";
    endfunction

    initial begin
        store_count_o   = 0;
        checked_count_o = 0;
        error_count_o   = 0;
        was_reset       = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            store_count_o = 0;  // each run starts the list again.
            was_reset     = 1'b1;
        end else begin
            // fetch starts from address zero.
            if (was_reset && instruction_address_i !== 32'h0000_0000) begin
                $display("MISMATCH reset_pc: expected %h, actual %h",
                         32'h0000_0000, instruction_address_i);
                error_count_o++;
            end
            was_reset = 1'b0;
            if (stall_i && mem_operation_enable_i) begin
                $display("ERROR: memory enable raised while stall is high");
                error_count_o++;
            end
            if (mem_operation_enable_i && mem_write_enable_i) begin
                if (store_count_o >= expected_count_i) begin
                    $display("ERROR: store to %h beyond the expected list", mem_address_i);
                    error_count_o++;
                end else begin
                    if (mem_address_i !== expected_address_i[store_count_o]) begin
                        $display("MISMATCH %s address: expected %h, actual %h",
                                 test_name(store_count_o),
                                 expected_address_i[store_count_o], mem_address_i);
                        error_count_o++;
                    end
                    if (mem_data_i !== expected_data_i[store_count_o]) begin
                        $display("MISMATCH %s data: expected %h, actual %h",
                                 test_name(store_count_o),
                                 expected_data_i[store_count_o], mem_data_i);
                        error_count_o++;
                    end
                end
                store_count_o++;
                checked_count_o++;
            end
        end
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps
/* tb_clock
   20 ns testbench clock, reset held for 5 cycles at start and on each request. */
module tb_clock (
    input  logic reset_request_i,
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        forever begin
            @(posedge reset_request_i);
            @(posedge clk);
            #1 reset = 1'b1;
            repeat (5) @(posedge clk);
            #1 reset = 1'b0;  // released between edges.
        end
    end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
/* tb_rv_core
   testbench top. instruction and data memory models around the core, one run without
   stall and one rerun after reset with random stall cycles. */
module tb_rv_core;
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk, reset, reset_request, stall_i, random_stall, timed_out;
    logic [31:0] instruction_i, mem_data_i, instruction_address_o;
    logic [31:0] mem_address_o, mem_data_o;
    logic        mem_operation_enable_o, mem_write_enable_o;
    logic [31:0] vectors [0:127];
    logic [31:0] data_memory [0:255];
    logic [31:0] expected_address [0:15];
    logic [31:0] expected_data [0:15];
    logic [31:0] fetch_address, read_data;
    logic [15:0] lfsr;
    int          expected_count, store_count, checked_count, error_count;

    tb_clock i_tb_clock (.reset_request_i(reset_request), .clk(clk), .reset(reset));

    rv_core i_rv_core (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .instruction_i(instruction_i), .mem_data_i(mem_data_i),
        .instruction_address_o(instruction_address_o),
        .mem_address_o(mem_address_o), .mem_data_o(mem_data_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o(mem_write_enable_o)
    );

    tb_checker i_tb_checker (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .instruction_address_i(instruction_address_o),
        .mem_operation_enable_i(mem_operation_enable_o),
        .mem_write_enable_i(mem_write_enable_o),
        .mem_address_i(mem_address_o), .mem_data_i(mem_data_o),
        .expected_address_i(expected_address), .expected_data_i(expected_data),
        .expected_count_i(expected_count), .store_count_o(store_count),
        .checked_count_o(checked_count), .error_count_o(error_count)
    );

    // taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // memories answer one cycle after the request.
    always @(posedge clk) begin
        fetch_address = instruction_address_o;
        if (mem_operation_enable_o && mem_write_enable_o) begin
            data_memory[mem_address_o[9:2]] = mem_data_o;
        end else if (mem_operation_enable_o) begin
            read_data = data_memory[mem_address_o[9:2]];
        end
        #1;
        instruction_i = (fetch_address[31:8] == 24'd0) ? vectors[fetch_address[7:2]] : '0;
        mem_data_i    = read_data;
        if (random_stall) begin
            lfsr    = lfsr_next(lfsr);
            stall_i = lfsr[0];
        end else begin
            stall_i = 1'b0;
        end
    end

    task automatic wait_for_reset_assert();
        int cycles;
        cycles = 0;
        while (reset !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b1) begin
            $display("ERROR: reset was never asserted for the rerun");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("ERROR: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_stores(input string run_name);
        int cycles;
        cycles = 0;
        while (store_count < expected_count && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < expected_count) begin
            $display("ERROR: %s run, program did not finish within %0d cycles",
                     run_name, TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);  // let trailing wrong-path stores show up.
        end
    endtask

    initial begin
        for (int i = 0; i < 128; i++) vectors[i] = '0;
        for (int i = 0; i < 256; i++) data_memory[i] = '0;
        $readmemh("core_vectors.hex", vectors);
        expected_count = int'(vectors[64]);
        for (int i = 0; i < 16; i++) begin
            expected_address[i] = vectors[65 + 2 * i];
            expected_data[i]    = vectors[66 + 2 * i];
        end
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        read_data     = '0;
        reset_request = 1'b0;
        random_stall  = 1'b0;
        timed_out     = 1'b0;
        lfsr          = 16'd59156;

        wait_for_reset_release();
        if (!timed_out) wait_for_stores("no-stall");
        if (!timed_out) begin
            reset_request = 1'b1;
            wait_for_reset_assert();
            reset_request = 1'b0;
            if (!timed_out) wait_for_reset_release();
            random_stall = 1'b1;
            if (!timed_out) wait_for_stores("random-stall");
            random_stall = 1'b0;
        end

        $display("stores checked: %0d, errors: %0d", checked_count, error_count);
        if (error_count == 0 && !timed_out && checked_count == 2 * expected_count) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rv_pkg.sv
fetch.sv
decode.sv
regbank.sv
execute.sv
retire.sv
rv_core.sv
tb_clock.sv
tb_checker.sv
tb_rv_core.sv
